// ==== include/aes_sbox.svh ====
`ifndef AES_SBOX_SVH
`define AES_SBOX_SVH

// ########################################
// Forward S-box, FIPS-197 figure 7
// ########################################

// Row major table, entry n is the substitute for byte value n
localparam logic [BYTE_S-1:0] SBOX [256] = '{
	8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
	8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
	8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
	8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
	8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
	8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
	8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
	8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
	8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
	8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
	8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
	8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
	8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
	8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
	8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
	8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
	8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
	8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
	8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
	8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
	8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
	8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
	8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
	8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
	8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
	8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
	8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
	8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
	8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
	8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
	8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
	8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

function automatic logic [BYTE_S-1:0] get_sbox(input logic [BYTE_S-1:0] b);
	return SBOX[b]; // Pure table lookup, maps to ROM or LUTs
endfunction

`endif

// ==== source/aes_types_pkg.sv ====
package aes_types_pkg;

	// ########################################
	// Data path sizes
	// ########################################

	localparam int BLK_S     = 128; // One AES block
	localparam int WORD_S    = 32; // One column of the state
	localparam int BYTE_S    = 8;
	localparam int KEY_MAX_S = 256; // AES-256 key, shorter keys sit in the upper bits
	localparam int NK_MAX    = KEY_MAX_S / WORD_S; // Longest key in words

	localparam int RND_W       = 4; // Holds round numbers up to 14
	localparam int SCHED_WORDS = 60; // 15 round keys of 4 words each
	localparam int SCHED_AW    = 6; // Addresses words 0 to 59

	// Supported cipher key lengths
	typedef enum logic [1:0] {
		KEY_128,
		KEY_192,
		KEY_256
	} key_len_t;

	// Number of 32 bit words in the cipher key
	function automatic logic [3:0] key_nk(input key_len_t len);
		case (len)
			KEY_192: return 4'd6;
			KEY_256: return 4'd8;
			default: return 4'd4; // Unused encoding falls back to AES-128
		endcase
	endfunction

	// Number of rounds, the schedule holds one more round key than this
	function automatic logic [RND_W-1:0] key_nr(input key_len_t len);
		case (len)
			KEY_192: return 4'd12;
			KEY_256: return 4'd14;
			default: return 4'd10;
		endcase
	endfunction

endpackage

// ==== source/aes_math_pkg.sv ====
package aes_math_pkg;

	import aes_types_pkg::*;

	`include "aes_sbox.svh"

	// ########################################
	// Field selection, index 0 is the MSB end
	// ########################################

	// Byte idx of a word, byte 0 is the top row of a column
	function automatic logic [BYTE_S-1:0] aes_byte(input logic [WORD_S-1:0] w,
		input logic [1:0] idx);
		return w[WORD_S-1-idx*BYTE_S -: BYTE_S];
	endfunction

	// Column idx of the state block
	function automatic logic [WORD_S-1:0] aes_word(input logic [BLK_S-1:0] blk,
		input logic [1:0] idx);
		return blk[BLK_S-1-idx*WORD_S -: WORD_S];
	endfunction

	// ########################################
	// GF(2^8) arithmetic, polynomial 0x11b
	// ########################################

	// Doubling is a left shift with conditional reduction
	function automatic logic [BYTE_S-1:0] gm2(input logic [BYTE_S-1:0] b);
		return {b[BYTE_S-2:0], 1'b0} ^ (b[BYTE_S-1] ? 8'h1b : 8'h00);
	endfunction

	// Tripling is doubling plus the original byte
	function automatic logic [BYTE_S-1:0] gm3(input logic [BYTE_S-1:0] b);
		return gm2(b) ^ b;
	endfunction

	// ########################################
	// Key schedule word operations
	// ########################################

	// S-box applied to each byte of a word
	function automatic logic [WORD_S-1:0] sub_word(input logic [WORD_S-1:0] w);
		return {get_sbox(aes_byte(w, 2'd0)), get_sbox(aes_byte(w, 2'd1)),
			get_sbox(aes_byte(w, 2'd2)), get_sbox(aes_byte(w, 2'd3))};
	endfunction

	// Cyclic byte rotation, top byte moves to the bottom
	function automatic logic [WORD_S-1:0] rot_word(input logic [WORD_S-1:0] w);
		return {w[WORD_S-BYTE_S-1:0], w[WORD_S-1 -: BYTE_S]};
	endfunction

	// Round constants x^(i-1), AES-128 needs all ten
	localparam logic [BYTE_S-1:0] RCON [10] = '{
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

endpackage

// ==== source/key_expander.sv ====
`timescale 1ns/1ps

module key_expander (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 key_load,
	input  aes_types_pkg::key_len_t              key_len,
	input  logic [aes_types_pkg::KEY_MAX_S-1:0]  cipher_key,
	output logic                                 sched_we,
	output logic [aes_types_pkg::SCHED_AW-1:0]   sched_addr,
	output logic [aes_types_pkg::WORD_S-1:0]     sched_word,
	output logic [aes_types_pkg::RND_W-1:0]      rounds_total,
	output logic                                 key_ready
);

	import aes_types_pkg::*;
	import aes_math_pkg::*;

	typedef enum logic [1:0] {
		IDLE, // Schedule complete or never loaded
		COPY, // Writing the raw key words
		EXPAND // Deriving the remaining words
	} state_t;

	state_t state;

	logic [KEY_MAX_S-1:0] key_reg; // Shifts up one word per COPY cycle
	logic [WORD_S-1:0] win [NK_MAX]; // win[0] is w[i-1], win[Nk-1] is w[i-Nk]
	logic [SCHED_AW-1:0] word_idx; // Index i of the word being written
	logic [2:0] kcnt; // Tracks i mod Nk
	logic [2:0] nk_last; // Nk-1 for the loaded key
	logic [3:0] rc_idx; // Next round constant to use
	logic is_256; // Enables the extra SubWord step
	logic [WORD_S-1:0] temp;
	logic [WORD_S-1:0] derived;
	logic [SCHED_AW-1:0] last_idx;

	// ########################################
	// Next schedule word
	// ########################################

	assign last_idx = {rounds_total, 2'b11}; // Word 4*(Nr+1)-1

	always_comb begin
		temp = win[0]; // Plain case reuses the previous word
		if (kcnt == 3'd0)
			temp = sub_word(rot_word(win[0])) ^ {RCON[rc_idx], 24'h0}; // Start of a key length
		else if (is_256 && kcnt == 3'd4)
			temp = sub_word(win[0]); // Mid-key step only AES-256 has
		derived = win[nk_last] ^ temp;
	end

	assign sched_we = (state != IDLE);
	assign sched_addr = word_idx;
	assign sched_word = (state == COPY) ? key_reg[KEY_MAX_S-1 -: WORD_S] : derived;

	// ########################################
	// Control FSM
	// ########################################

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			key_ready <= 1'b0;
			rounds_total <= '0;
			word_idx <= '0;
			kcnt <= '0;
			nk_last <= '0;
			rc_idx <= '0;
			is_256 <= 1'b0;
		end else if (key_load) begin
			state <= COPY; // A reload restarts the schedule from word 0
			key_ready <= 1'b0;
			rounds_total <= key_nr(key_len);
			nk_last <= 3'(key_nk(key_len) - 4'd1);
			is_256 <= (key_len == KEY_256);
			word_idx <= '0;
			kcnt <= '0;
			rc_idx <= '0;
		end else if (state != IDLE) begin
			word_idx <= word_idx + 1'b1;
			kcnt <= (kcnt == nk_last) ? 3'd0 : kcnt + 1'b1;

			if (state == EXPAND && kcnt == 3'd0)
				rc_idx <= rc_idx + 1'b1; // Constant consumed by this word

			if (state == COPY && kcnt == nk_last)
				state <= EXPAND; // Raw key fully written

			if (state == EXPAND && word_idx == last_idx) begin
				state <= IDLE;
				key_ready <= 1'b1; // Schedule ready the cycle after the last write
			end
		end
	end

	// Key and window hold payload only
	always_ff @(posedge clk) begin
		if (key_load)
			key_reg <= cipher_key;
		else if (state == COPY)
			key_reg <= key_reg << WORD_S; // Expose the next key word at the top

		if (state != IDLE) begin
			win[0] <= sched_word; // Every written word enters the window
			for (int j = 1; j < NK_MAX; j++)
				win[j] <= win[j-1];
		end
	end

endmodule

// ==== source/round_key_store.sv ====
`timescale 1ns/1ps

module round_key_store (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                sched_we,
	input  logic [aes_types_pkg::SCHED_AW-1:0]  sched_addr,
	input  logic [aes_types_pkg::WORD_S-1:0]    sched_word,
	input  logic                                key_req,
	input  logic [aes_types_pkg::RND_W-1:0]     round_key_no,
	output logic                                key_valid,
	output logic [aes_types_pkg::BLK_S-1:0]     key
);

	import aes_types_pkg::*;

	logic [WORD_S-1:0] mem [SCHED_WORDS]; // Expanded schedule, word per entry

	// One word per cycle from the expander
	always_ff @(posedge clk) begin
		if (sched_we)
			mem[sched_addr] <= sched_word;
	end

	// Round key N lives at words 4N to 4N+3, low address bits select the column
	always_ff @(posedge clk) begin
		if (key_req)
			key <= {mem[{round_key_no, 2'd0}], mem[{round_key_no, 2'd1}],
				mem[{round_key_no, 2'd2}], mem[{round_key_no, 2'd3}]};
	end

	always_ff @(posedge clk) begin
		if (reset)
			key_valid <= 1'b0;
		else
			key_valid <= key_req; // Key follows the request by one cycle
	end

endmodule

// ==== source/cipher.sv ====
`timescale 1ns/1ps

module cipher (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             en,
	input  logic [aes_types_pkg::BLK_S-1:0]  plaintext,
	input  logic [aes_types_pkg::RND_W-1:0]  rounds_total,
	input  logic [aes_types_pkg::BLK_S-1:0]  key,
	input  logic                             key_valid,
	output logic                             key_req,
	output logic [aes_types_pkg::BLK_S-1:0]  ciphertext,
	output logic [aes_types_pkg::RND_W-1:0]  round_key_no,
	output logic                             en_o
);

	import aes_types_pkg::*;
	import aes_math_pkg::*;

	// ########################################
	// Round transformations
	// ########################################

	// SubBytes works column by column with the key schedule helper
	function automatic logic [BLK_S-1:0] sub_bytes(input logic [BLK_S-1:0] blk);
		return {sub_word(aes_word(blk, 2'd0)), sub_word(aes_word(blk, 2'd1)),
			sub_word(aes_word(blk, 2'd2)), sub_word(aes_word(blk, 2'd3))};
	endfunction

	// Row r rotates left by r, so column c takes row r from column c+r
	function automatic logic [BLK_S-1:0] shift_rows(input logic [BLK_S-1:0] blk);
		logic [WORD_S-1:0] w0, w1, w2, w3;
		w0 = aes_word(blk, 2'd0);
		w1 = aes_word(blk, 2'd1);
		w2 = aes_word(blk, 2'd2);
		w3 = aes_word(blk, 2'd3);
		return {aes_byte(w0, 2'd0), aes_byte(w1, 2'd1), aes_byte(w2, 2'd2), aes_byte(w3, 2'd3),
			aes_byte(w1, 2'd0), aes_byte(w2, 2'd1), aes_byte(w3, 2'd2), aes_byte(w0, 2'd3),
			aes_byte(w2, 2'd0), aes_byte(w3, 2'd1), aes_byte(w0, 2'd2), aes_byte(w1, 2'd3),
			aes_byte(w3, 2'd0), aes_byte(w0, 2'd1), aes_byte(w1, 2'd2), aes_byte(w2, 2'd3)};
	endfunction

	// One column times the circulant matrix {02 03 01 01}
	function automatic logic [WORD_S-1:0] mix_word(input logic [WORD_S-1:0] w);
		logic [BYTE_S-1:0] b0, b1, b2, b3;
		b0 = aes_byte(w, 2'd0);
		b1 = aes_byte(w, 2'd1);
		b2 = aes_byte(w, 2'd2);
		b3 = aes_byte(w, 2'd3);
		return {gm2(b0) ^ gm3(b1) ^ b2 ^ b3,
			b0 ^ gm2(b1) ^ gm3(b2) ^ b3,
			b0 ^ b1 ^ gm2(b2) ^ gm3(b3),
			gm3(b0) ^ b1 ^ b2 ^ gm2(b3)};
	endfunction

	function automatic logic [BLK_S-1:0] mix_cols(input logic [BLK_S-1:0] blk);
		return {mix_word(aes_word(blk, 2'd0)), mix_word(aes_word(blk, 2'd1)),
			mix_word(aes_word(blk, 2'd2)), mix_word(aes_word(blk, 2'd3))};
	endfunction

	// ########################################
	// Round data path
	// ########################################

	logic [BLK_S-1:0] state_sub; // After SubBytes
	logic [BLK_S-1:0] state_shift; // After ShiftRows, last round stops here
	logic [BLK_S-1:0] state_mix; // After MixColumns
	logic [RND_W-1:0] round_no; // Round applied when the next key arrives
	logic first_round;
	logic last_round;
	logic last_key;

	always_comb begin
		state_sub = sub_bytes(ciphertext); // The output register doubles as the state
		state_shift = shift_rows(state_sub);
		state_mix = mix_cols(state_shift);
	end

	assign first_round = (round_no == '0);
	assign last_round = (round_no == rounds_total);
	assign last_key = (round_key_no == rounds_total);

	// Key request counter, keys 0 to Nr are asked for on consecutive cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			key_req <= 1'b0;
			round_key_no <= '0;
		end else if (last_key) begin
			key_req <= 1'b0; // Final key requested, wrap for the next block
			round_key_no <= '0;
		end else begin
			if (en)
				key_req <= 1'b1;
			if (key_req)
				round_key_no <= round_key_no + 1'b1;
		end
	end

	// State update, one round per arriving key
	always_ff @(posedge clk) begin
		if (key_valid) begin
			if (first_round)
				ciphertext <= plaintext ^ key; // Initial AddRoundKey
			else if (last_round)
				ciphertext <= state_shift ^ key; // No MixColumns in the final round
			else
				ciphertext <= state_mix ^ key;
		end
	end

	// Round counter and completion pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			round_no <= '0;
			en_o <= 1'b0;
		end else begin
			en_o <= key_valid && last_round; // Ciphertext is final on this cycle
			if (key_valid)
				round_no <= last_round ? '0 : round_no + 1'b1;
		end
	end

endmodule

// ==== source/aes_core.sv ====
`timescale 1ns/1ps

module aes_core (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 key_load,
	input  logic                                 start,
	input  aes_types_pkg::key_len_t              key_len,
	input  logic [aes_types_pkg::KEY_MAX_S-1:0]  cipher_key,
	input  logic [aes_types_pkg::BLK_S-1:0]      plaintext,
	output logic                                 key_ready,
	output logic [aes_types_pkg::BLK_S-1:0]      ciphertext,
	output logic                                 done
);

	import aes_types_pkg::*;

	// ########################################
	// Schedule write port
	// ########################################

	logic sched_we;
	logic [SCHED_AW-1:0] sched_addr;
	logic [WORD_S-1:0] sched_word;

	// ########################################
	// Round key request and response
	// ########################################

	logic [RND_W-1:0] rounds_total; // Nr of the loaded key
	logic key_req;
	logic [RND_W-1:0] round_key_no;
	logic key_valid;
	logic [BLK_S-1:0] round_key;

	key_expander u_key_expander (
		.clk          (clk),
		.reset        (reset),
		.key_load     (key_load),
		.key_len      (key_len),
		.cipher_key   (cipher_key),
		.sched_we     (sched_we),
		.sched_addr   (sched_addr),
		.sched_word   (sched_word),
		.rounds_total (rounds_total),
		.key_ready    (key_ready)
	);

	round_key_store u_round_key_store (
		.clk          (clk),
		.reset        (reset),
		.sched_we     (sched_we),
		.sched_addr   (sched_addr),
		.sched_word   (sched_word),
		.key_req      (key_req),
		.round_key_no (round_key_no),
		.key_valid    (key_valid),
		.key          (round_key)
	);

	// The engine starts on start and its completion pulse is done
	cipher u_cipher (
		.clk          (clk),
		.reset        (reset),
		.en           (start),
		.plaintext    (plaintext),
		.rounds_total (rounds_total),
		.key          (round_key),
		.key_valid    (key_valid),
		.key_req      (key_req),
		.ciphertext   (ciphertext),
		.round_key_no (round_key_no),
		.en_o         (done)
	);

endmodule

// ==== tb/aes_ref_pkg.sv ====
package aes_ref_pkg;

	import aes_types_pkg::*;

	// Three known vectors plus 30 random keys, each with a load and four blocks
	localparam int RUN_LIMIT = 33 * (62 + 4 * 20) + 100;

	logic [7:0] sbox_tab [256]; // Filled once by build_sbox

	// ########################################
	// GF(2^8) arithmetic
	// ########################################

	// Shift and add multiply, reduced by 0x11b
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p ^= x;
			x = (x << 1) ^ (x[7] ? 8'h1b : 8'h00); // Doubling with reduction
		end
		return p;
	endfunction

	// Inverse is a^254, zero maps to zero on its own
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] p;
		logic [7:0] r;
		p = gf_mul(a, a);
		r = p;
		for (int i = 0; i < 6; i++) begin
			p = gf_mul(p, p); // Next power of two of a
			r = gf_mul(r, p);
		end
		return r;
	endfunction

	// Inversion followed by the affine map
	function automatic void build_sbox();
		logic [7:0] inv;
		logic [7:0] s;
		for (int b = 0; b < 256; b++) begin
			inv = gf_inv(8'(b));
			s = inv ^ 8'h63;
			for (int n = 1; n <= 4; n++)
				s ^= (inv << n) | (inv >> (8 - n)); // Rotate left by n
			sbox_tab[b] = s;
		end
	endfunction

	function automatic logic [31:0] sbox_word(input logic [31:0] w);
		return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
	endfunction

	// ########################################
	// Block encryption
	// ########################################

	function automatic logic [127:0] encrypt_block(input key_len_t len,
		input logic [255:0] key, input logic [127:0] pt);
		logic [31:0] w [60];
		logic [7:0] s [16]; // Byte 4*c+r is row r of column c
		logic [7:0] t [16];
		logic [31:0] tmp;
		logic [7:0] rc;
		logic [127:0] ct;
		int nk;
		int nr;
		nk = key_nk(len);
		nr = key_nr(len);
		rc = 8'h01;
		for (int i = 0; i < 4 * (nr + 1); i++) begin
			if (i < nk) begin
				w[i] = key[255 - 32 * i -: 32]; // Key words from the top down
			end else begin
				tmp = w[i - 1];
				if (i % nk == 0) begin
					tmp = sbox_word({tmp[23:0], tmp[31:24]}) ^ {rc, 24'h0};
					rc = gf_mul(rc, 8'h02);
				end else if (nk == 8 && i % 8 == 4) begin
					tmp = sbox_word(tmp);
				end
				w[i] = w[i - nk] ^ tmp;
			end
		end
		for (int k = 0; k < 16; k++)
			s[k] = pt[127 - 8 * k -: 8] ^ w[k / 4][31 - 8 * (k % 4) -: 8];
		for (int rnd = 1; rnd <= nr; rnd++) begin
			for (int c = 0; c < 4; c++)
				for (int r = 0; r < 4; r++)
					t[4 * c + r] = sbox_tab[s[4 * ((c + r) % 4) + r]]; // SubBytes and ShiftRows
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					if (rnd < nr)
						s[4 * c + r] = gf_mul(t[4 * c + r], 8'h02)
							^ gf_mul(t[4 * c + (r + 1) % 4], 8'h03)
							^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
					else
						s[4 * c + r] = t[4 * c + r]; // Final round skips MixColumns
				end
				for (int r = 0; r < 4; r++)
					s[4 * c + r] ^= w[4 * rnd + c][31 - 8 * r -: 8];
			end
		end
		for (int k = 0; k < 16; k++)
			ct[127 - 8 * k -: 8] = s[k];
		return ct;
	endfunction

endpackage

// ==== tb/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb;

	import aes_types_pkg::*;
	import aes_ref_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic key_load;
	logic start;
	key_len_t key_len;
	logic [KEY_MAX_S-1:0] cipher_key;
	logic [BLK_S-1:0] plaintext;
	logic key_ready;
	logic [BLK_S-1:0] ciphertext;
	logic done;

	int seed;
	int data_errors = 0;
	int timing_errors = 0;
	int cycles = 0;
	int cur_nr = 0; // Nr of the loaded key, used by the done monitor
	int age = -1; // Cycles since the last start, -1 when idle

	aes_core DUT (.*);

	always #10 clk = ~clk; // 20 ns period

	// ########################################
	// Run limit and done timing monitor
	// ########################################

	always @(posedge clk) begin
		cycles++;
		if (cycles >= RUN_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// done must be high only in cycle Nr+3 after start
	always @(negedge clk) begin
		if (start)
			age = 0;
		else if (age >= 0 && age < 64)
			age = age + 1;
		else
			age = -1;
		assert (done === (age == cur_nr + 3)) else begin
			timing_errors++;
			$display("FAIL done timing: expected %0b actual %0b at %0d cycles after start",
				age == cur_nr + 3, done, age);
		end
	end

	// ########################################
	// Stimulus tasks
	// ########################################

	task automatic random_bits(output logic [255:0] v);
		for (int i = 0; i < 8; i++)
			v[32 * i +: 32] = $random(seed);
	endtask

	task automatic load_key(input key_len_t len, input logic [255:0] k);
		int lat;
		int limit;
		limit = 4 * (key_nr(len) + 1) + 2; // Schedule length plus two
		@(posedge clk);
		key_load <= 1'b1;
		key_len <= len;
		cipher_key <= k;
		@(posedge clk);
		key_load <= 1'b0;
		@(negedge clk);
		assert (key_ready === 1'b0) else begin
			timing_errors++;
			$display("key_ready did not fall the cycle after key_load");
		end
		lat = 1;
		while (key_ready !== 1'b1 && lat <= limit) begin
			@(negedge clk);
			lat++;
		end
		assert (key_ready === 1'b1 && lat <= limit) else begin
			timing_errors++;
			$display("key_ready did not rise within %0d cycles of key_load", limit);
		end
		cur_nr = key_nr(len);
	endtask

	task automatic run_block(input string name, input logic [127:0] pt,
		input logic [127:0] exp_ct);
		int lat;
		@(posedge clk);
		start <= 1'b1;
		plaintext <= pt; // Held until the next block
		@(posedge clk);
		start <= 1'b0;
		lat = 0;
		while (done !== 1'b1 && lat < 40) begin
			@(negedge clk);
			lat++;
		end
		assert (done === 1'b1) else begin
			data_errors++;
			$display("%s: done never pulsed after start", name);
		end
		if (done === 1'b1) begin
			assert (ciphertext === exp_ct) else begin
				data_errors++;
				$display("FAIL %s: expected %h actual %h", name, exp_ct, ciphertext);
			end
		end
	endtask

	// Model and DUT are both held to the published ciphertext
	task automatic check_fips(input string name, input key_len_t len,
		input logic [255:0] k, input logic [127:0] ct);
		logic [127:0] pt;
		logic [127:0] model_ct;
		pt = 128'h00112233445566778899aabbccddeeff;
		model_ct = encrypt_block(len, k, pt);
		assert (model_ct === ct) else begin
			data_errors++;
			$display("FAIL %s model: expected %h actual %h", name, ct, model_ct);
		end
		load_key(len, k);
		run_block(name, pt, ct);
	endtask

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		key_len_t len;
		logic [255:0] k;
		logic [255:0] r;
		seed = 32'hd311;
		reset = 1'b1;
		key_load = 1'b0;
		start = 1'b0;
		key_len = KEY_128;
		cipher_key = '0;
		plaintext = '0;
		build_sbox();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (key_ready === 1'b0 && done === 1'b0) else begin
			timing_errors++;
			$display("key_ready or done high after reset");
		end

		check_fips("fips 128", KEY_128, {128'h000102030405060708090a0b0c0d0e0f, 128'h0},
			128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		check_fips("fips 192", KEY_192,
			{192'h000102030405060708090a0b0c0d0e0f1011121314151617, 64'h0},
			128'hdda97ca4864cdfe06eaf70a0ec0d7191);
		check_fips("fips 256", KEY_256,
			256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f,
			128'h8ea2b7ca516745bfeafc49904b496089);

		// Every reload changes the key length, so stale words would show up
		for (int n = 0; n < 30; n++) begin
			len = key_len_t'(n % 3);
			random_bits(k); // Bits below a short key are random and must not reach the schedule
			load_key(len, k);
			for (int b = 0; b < 4; b++) begin
				random_bits(r);
				run_block($sformatf("random key %0d block %0d", n, b), r[127:0],
					encrypt_block(len, k, r[127:0]));
			end
		end

		repeat (4) @(posedge clk);
		$display("Errors: data %0d, timing %0d", data_errors, timing_errors);
		if (data_errors == 0 && timing_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
source/aes_types_pkg.sv
source/aes_math_pkg.sv
source/key_expander.sv
source/round_key_store.sv
source/cipher.sv
source/aes_core.sv
tb/aes_ref_pkg.sv
tb/aes_core_tb.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - include_dirs:
      - include
    files:
      - source/aes_types_pkg.sv
      - source/aes_math_pkg.sv
      - source/key_expander.sv
      - source/round_key_store.sv
      - source/cipher.sv
      - source/aes_core.sv
  - target: test
    files:
      - tb/aes_ref_pkg.sv
      - tb/aes_core_tb.sv
